//--- src/icache_pkg.sv
`default_nettype none

package icache_pkg;

    localparam int DATA_W     = 32; // CPU and memory word width
    localparam int BYTE_OFS_W = 2;  // Byte lane select bits within a word

    // CPU access width, same encoding as the fetch port
    typedef enum logic [1:0] {
        WIDTH_BYTE = 2'b00,
        WIDTH_HALF = 2'b01,
        WIDTH_WORD = 2'b10
    } access_width_e;

    // CPU response code
    typedef enum logic [1:0] {
        RESP_NONE = 2'b00,
        RESP_LAST = 2'b11   // Data valid, access complete
    } resp_e;

    // Pick the addressed lanes of a word, right aligned and zero extended
    function automatic logic [DATA_W-1:0] select_rdata(
        input access_width_e         width,
        input logic [BYTE_OFS_W-1:0] ofs,
        input logic [DATA_W-1:0]     word
    );
        logic [DATA_W-1:0] res;
        res = '0;
        case (width)
            WIDTH_BYTE: res[7:0]  = word[8*ofs +: 8];
            WIDTH_HALF: res[15:0] = word[16*ofs[BYTE_OFS_W-1] +: 16]; // Upper or lower half
            default:    res       = word;
        endcase
        return res;
    endfunction

endpackage

`default_nettype wire

//--- src/icache_fill_if.sv
`timescale 1ns/100ps
`default_nettype none

// Refill engine to line store, plain strobes with no handshake
interface icache_fill_if
    import icache_pkg::*;
#(
    parameter int ADDR_W = 16,
    parameter int WORDS  = 8
) ();
    localparam int WPTR_W = $clog2(WORDS);
    localparam int TAG_W  = ADDR_W - WPTR_W - BYTE_OFS_W;

    logic              word_wr;   // One refill word this cycle
    logic [WPTR_W-1:0] word_ptr;  // Word position in the line
    logic [DATA_W-1:0] word_data;
    logic              tag_wr;    // Line complete, commit tag
    logic [TAG_W-1:0]  tag_val;

    modport refill (output word_wr, word_ptr, word_data, tag_wr, tag_val);
    modport store  (input  word_wr, word_ptr, word_data, tag_wr, tag_val);
endinterface

// Lookup FSM to line store, tag compare and data read
interface icache_lookup_if
    import icache_pkg::*;
#(
    parameter int ADDR_W = 16,
    parameter int LINES  = 4,
    parameter int WORDS  = 8
) ();
    localparam int WPTR_W = $clog2(WORDS);
    localparam int IDX_W  = $clog2(LINES);
    localparam int TAG_W  = ADDR_W - WPTR_W - BYTE_OFS_W;

    logic [TAG_W-1:0]        cmp_tag;  // Tag under test
    logic                    hit;      // Combinational from cmp_tag
    logic [IDX_W-1:0]        hit_idx;  // Matching line
    logic                    rd_en;
    logic [IDX_W+WPTR_W-1:0] rd_addr;  // {line, word}
    logic [DATA_W-1:0]       rd_data;  // Valid one cycle after rd_en

    modport lookup (output cmp_tag, rd_en, rd_addr, input hit, hit_idx, rd_data);
    modport store  (input cmp_tag, rd_en, rd_addr, output hit, hit_idx, rd_data);
endinterface

`default_nettype wire

//--- src/icache_refill.sv
`timescale 1ns/100ps
`default_nettype none

module icache_refill
    import icache_pkg::*;
#(
    parameter int ADDR_W = 16,
    parameter int WORDS  = 8
) (
    input  wire logic              mclk,
    input  wire logic              rst_n,

    input  wire logic              refill_req_i,   // Level, held until busy
    input  wire logic [ADDR_W-1:0] refill_addr_i,  // Line aligned
    output logic                   refill_busy_o,

    output logic                   mem_req_o,
    output logic [ADDR_W-1:0]      mem_addr_o,
    output logic [$clog2(WORDS+1)-1:0] mem_bl_o,
    input  wire logic [DATA_W-1:0] mem_rdata_i,
    input  wire logic              mem_ack_i,      // One per word
    input  wire logic              mem_lack_i,     // With the last word

    icache_fill_if.refill          fill
);

    localparam int WPTR_W   = $clog2(WORDS);
    localparam int LINE_OFS = WPTR_W + BYTE_OFS_W;
    localparam int BL_W     = $clog2(WORDS+1);

    logic [WPTR_W-1:0] word_cnt;   // Words received so far
    logic              start;
    logic              word_ack;

    assign start    = refill_req_i & ~refill_busy_o;
    assign word_ack = mem_ack_i & mem_req_o;     // Ignore stray acks when idle

    assign mem_bl_o     = BL_W'(WORDS);          // Always a whole line
    assign fill.tag_val = mem_addr_o[ADDR_W-1:LINE_OFS];

    //------------------------------------------------------------
    // Burst control
    //------------------------------------------------------------
    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            refill_busy_o <= 1'b0;
            mem_req_o     <= 1'b0;
            word_cnt      <= '0;
            fill.word_wr  <= 1'b0;
            fill.tag_wr   <= 1'b0;
        end else begin
            fill.word_wr <= word_ack;                 // Store one cycle behind the bus
            fill.tag_wr  <= word_ack & mem_lack_i;    // Tag goes with the last word
            if (start) begin
                refill_busy_o <= 1'b1;
                mem_req_o     <= 1'b1;
                word_cnt      <= '0;
            end else if (refill_busy_o) begin
                if (word_ack) word_cnt <= word_cnt + 1'b1;
                if (word_ack && mem_lack_i) mem_req_o <= 1'b0;   // Burst done
                if (fill.tag_wr) refill_busy_o <= 1'b0;        // Line committed
            end
        end
    end

    // Address and word payload
    always_ff @(posedge mclk) begin
        if (start) mem_addr_o <= refill_addr_i;
        fill.word_data <= mem_rdata_i;
        fill.word_ptr  <= word_cnt;   // Position of the word being acked
    end

endmodule

`default_nettype wire

//--- src/icache_line_store.sv
`timescale 1ns/100ps
`default_nettype none

module icache_line_store
    import icache_pkg::*;
#(
    parameter int ADDR_W = 16,
    parameter int LINES  = 4,
    parameter int WORDS  = 8
) (
    input  wire logic       mclk,
    input  wire logic       rst_n,
    icache_fill_if.store    fill,
    icache_lookup_if.store  lk
);

    localparam int WPTR_W = $clog2(WORDS);
    localparam int IDX_W  = $clog2(LINES);
    localparam int TAG_W  = ADDR_W - WPTR_W - BYTE_OFS_W;

    logic [DATA_W-1:0] mem [LINES*WORDS];   // Line data, {line, word} index
    logic [TAG_W-1:0]  tags [LINES];
    logic [LINES-1:0]  valid;
    logic [IDX_W-1:0]  fifo_ptr;             // Next line to replace

    //------------------------------------------------------------
    // Refill side
    //------------------------------------------------------------
    always_ff @(posedge mclk) begin
        if (fill.word_wr) mem[{fifo_ptr, fill.word_ptr}] <= fill.word_data;
        if (fill.tag_wr) tags[fifo_ptr] <= fill.tag_val;
    end

    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            valid    <= '0;
            fifo_ptr <= '0;
        end else begin
            // Victim line is invalid while partly overwritten
            if (fill.word_wr) valid[fifo_ptr] <= 1'b0;
            if (fill.tag_wr) begin
                valid[fifo_ptr] <= 1'b1;                // Wins over the clear above
                if (fifo_ptr == IDX_W'(LINES-1))
                    fifo_ptr <= '0;
                else
                    fifo_ptr <= fifo_ptr + 1'b1;
            end
        end
    end

    //------------------------------------------------------------
    // Lookup side
    //------------------------------------------------------------
    // Fully associative compare across all valid lines
    always_comb begin
        lk.hit     = 1'b0;
        lk.hit_idx = '0;
        for (int i = 0; i < LINES; i++) begin
            if (valid[i] && (tags[i] == lk.cmp_tag)) begin
                lk.hit     = 1'b1;
                lk.hit_idx = IDX_W'(i);
            end
        end
    end

    // Registered read port
    always_ff @(posedge mclk) begin
        if (lk.rd_en) lk.rd_data <= mem[lk.rd_addr];
    end

endmodule

`default_nettype wire

//--- src/icache_lookup.sv
`timescale 1ns/100ps
`default_nettype none

module icache_lookup
    import icache_pkg::*;
#(
    parameter int ADDR_W = 16,
    parameter int WORDS  = 8
) (
    input  wire logic              mclk,
    input  wire logic              rst_n,

    input  wire logic              cpu_req_i,
    input  wire logic [ADDR_W-1:0] cpu_addr_i,
    input  wire logic [1:0]        cpu_width_i,
    output logic                   cpu_req_ack_o,  // One cycle pulse
    output logic [DATA_W-1:0]      cpu_rdata_o,
    output logic [1:0]             cpu_resp_o,

    output logic                   refill_req_o,
    output logic [ADDR_W-1:0]      refill_addr_o,
    input  wire logic              refill_busy_i,

    icache_lookup_if.lookup        lk
);

    localparam int WPTR_W   = $clog2(WORDS);
    localparam int LINE_OFS = WPTR_W + BYTE_OFS_W;

    typedef enum logic [2:0] {
        IDLE, TAG_COMPARE, READ_WAIT, READ_DONE, REFILL_WAIT, REFILL_DONE
    } state_e;

    state_e            state;
    logic [ADDR_W-1:0] addr_q;    // Latched CPU address
    access_width_e     width_q;
    logic              accept;

    assign accept     = (state == IDLE) && cpu_req_i;
    assign lk.cmp_tag = addr_q[ADDR_W-1:LINE_OFS];

    //------------------------------------------------------------
    // Control FSM
    //------------------------------------------------------------
    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= IDLE;
            cpu_req_ack_o <= 1'b0;
            cpu_resp_o    <= RESP_NONE;
            refill_req_o  <= 1'b0;
            lk.rd_en      <= 1'b0;
        end else begin
            cpu_req_ack_o <= 1'b0;
            cpu_resp_o    <= RESP_NONE;
            lk.rd_en      <= 1'b0;
            case (state)
                IDLE: if (accept) begin
                    cpu_req_ack_o <= 1'b1;
                    state         <= TAG_COMPARE;
                end
                TAG_COMPARE: if (lk.hit) begin
                    lk.rd_en <= 1'b1;                 // Read issue
                    state    <= READ_WAIT;
                end else begin
                    refill_req_o <= 1'b1;             // Miss, fetch the line
                    state        <= REFILL_WAIT;
                end
                READ_WAIT: state <= READ_DONE;        // rd_data lands this edge
                READ_DONE: begin
                    cpu_resp_o <= RESP_LAST;
                    state      <= IDLE;
                end
                REFILL_WAIT: if (refill_busy_i) begin
                    refill_req_o <= 1'b0;             // Engine has taken it
                    state        <= REFILL_DONE;
                end
                REFILL_DONE: if (!refill_busy_i) state <= TAG_COMPARE;  // Retry, now hits
                default: state <= IDLE;
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge mclk) begin
        if (accept) begin
            addr_q  <= cpu_addr_i;
            width_q <= access_width_e'(cpu_width_i);
        end
        if (state == TAG_COMPARE) begin
            lk.rd_addr    <= {lk.hit_idx, addr_q[LINE_OFS-1:BYTE_OFS_W]};
            refill_addr_o <= {addr_q[ADDR_W-1:LINE_OFS], {LINE_OFS{1'b0}}};  // Line aligned
        end
        if (state == READ_DONE)
            cpu_rdata_o <= select_rdata(width_q, addr_q[BYTE_OFS_W-1:0], lk.rd_data);
    end

endmodule

`default_nettype wire

//--- src/icache_top.sv
`timescale 1ns/100ps
`default_nettype none

module icache_top
    import icache_pkg::*;
#(
    parameter int ADDR_W = 16,   // Byte address width
    parameter int LINES  = 4,    // Cache lines
    parameter int WORDS  = 8     // Words per line
) (
    input  wire logic                     mclk,
    input  wire logic                     rst_n,

    // CPU fetch port
    input  wire logic                     cpu_req_i,
    input  wire logic [ADDR_W-1:0]        cpu_addr_i,
    input  wire logic [1:0]               cpu_width_i,
    output logic                          cpu_req_ack_o,
    output logic [DATA_W-1:0]             cpu_rdata_o,
    output logic [1:0]                    cpu_resp_o,

    // Burst read memory bus
    output logic                          mem_req_o,
    output logic [ADDR_W-1:0]             mem_addr_o,
    output logic [$clog2(WORDS+1)-1:0]    mem_bl_o,
    input  wire logic [DATA_W-1:0]        mem_rdata_i,
    input  wire logic                     mem_ack_i,
    input  wire logic                     mem_lack_i
);

    logic              refill_req;
    logic [ADDR_W-1:0] refill_addr;
    logic              refill_busy;

    icache_fill_if   #(.ADDR_W(ADDR_W), .WORDS(WORDS)) fill_if ();
    icache_lookup_if #(.ADDR_W(ADDR_W), .LINES(LINES), .WORDS(WORDS)) lookup_if ();

    //------------------------------------------------------------
    // CPU side FSM
    //------------------------------------------------------------
    icache_lookup #(.ADDR_W(ADDR_W), .WORDS(WORDS)) u_lookup (
        .mclk          (mclk),
        .rst_n         (rst_n),
        .cpu_req_i     (cpu_req_i),
        .cpu_addr_i    (cpu_addr_i),
        .cpu_width_i   (cpu_width_i),
        .cpu_req_ack_o (cpu_req_ack_o),
        .cpu_rdata_o   (cpu_rdata_o),
        .cpu_resp_o    (cpu_resp_o),
        .refill_req_o  (refill_req),
        .refill_addr_o (refill_addr),
        .refill_busy_i (refill_busy),
        .lk            (lookup_if.lookup)
    );

    // Memory side burst engine
    icache_refill #(.ADDR_W(ADDR_W), .WORDS(WORDS)) u_refill (
        .mclk          (mclk),
        .rst_n         (rst_n),
        .refill_req_i  (refill_req),
        .refill_addr_i (refill_addr),
        .refill_busy_o (refill_busy),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_bl_o      (mem_bl_o),
        .mem_rdata_i   (mem_rdata_i),
        .mem_ack_i     (mem_ack_i),
        .mem_lack_i    (mem_lack_i),
        .fill          (fill_if.refill)
    );

    icache_line_store #(.ADDR_W(ADDR_W), .LINES(LINES), .WORDS(WORDS)) u_line_store (
        .mclk  (mclk),
        .rst_n (rst_n),
        .fill  (fill_if.store),
        .lk    (lookup_if.store)
    );

endmodule

`default_nettype wire

//--- dv/icache_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module icache_assertions #(
    parameter int WORDS = 8
) (
    input wire logic                       mclk,
    input wire logic                       rst_n,
    input wire logic                       cpu_req_ack_o,
    input wire logic                       mem_req_o,
    input wire logic                       mem_ack_i,
    input wire logic                       mem_lack_i,
    input wire logic [$clog2(WORDS+1)-1:0] mem_bl_o
);

    // Acknowledge is a single cycle pulse
    ack_pulse: assert property (@(posedge mclk) disable iff (!rst_n)
        cpu_req_ack_o |=> !cpu_req_ack_o)
        else $error("cpu_req_ack_o held for more than one cycle");

    // Burst request stays up until the last word
    req_hold: assert property (@(posedge mclk) disable iff (!rst_n)
        (mem_req_o && !(mem_ack_i && mem_lack_i)) |=> mem_req_o)
        else $error("mem_req_o dropped before mem_lack_i");

    burst_len: assert property (@(posedge mclk) disable iff (!rst_n)
        mem_req_o |-> (mem_bl_o == WORDS))  // Always a whole line
        else $error("mem_bl_o differs from WORDS during a request");

endmodule

bind icache_top icache_assertions #(.WORDS(WORDS)) u_assertions (
    .mclk          (mclk),
    .rst_n         (rst_n),
    .cpu_req_ack_o (cpu_req_ack_o),
    .mem_req_o     (mem_req_o),
    .mem_ack_i     (mem_ack_i),
    .mem_lack_i    (mem_lack_i),
    .mem_bl_o      (mem_bl_o)
);

`default_nettype wire

//--- dv/tb_icache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_icache
    import icache_pkg::*;
;
    localparam int ADDR_W     = 16;
    localparam int LINES      = 4;
    localparam int WORDS      = 8;
    localparam int WPTR_W     = $clog2(WORDS);
    localparam int IDX_W      = $clog2(LINES);
    localparam int LINE_OFS   = WPTR_W + 2;
    localparam int TAG_W      = ADDR_W - LINE_OFS;
    localparam int LINE_BYTES = WORDS * 4;
    localparam int N_RAND     = 200;
    localparam int RAND_BASE  = 32'h4000;                     // Random reads stay in 2*LINES lines
    localparam int N_ACCESS   = 1 + WORDS + 8 + (LINES + 3) + N_RAND;
    localparam int TIMEOUT    = 40 * N_ACCESS * (WORDS + 10); // Cycles

    logic                       mclk = 1'b0;
    logic                       rst_n;
    logic                       cpu_req_i;
    logic [ADDR_W-1:0]          cpu_addr_i;
    logic [1:0]                 cpu_width_i;
    logic                       cpu_req_ack_o;
    logic [31:0]                cpu_rdata_o;
    logic [1:0]                 cpu_resp_o;
    logic                       mem_req_o;
    logic [ADDR_W-1:0]          mem_addr_o;
    logic [$clog2(WORDS+1)-1:0] mem_bl_o;
    logic [31:0]                mem_rdata_i;
    logic                       mem_ack_i;
    logic                       mem_lack_i;

    logic [31:0]      exp_q [$];        // Expected read data in issue order
    logic [31:0]      lfsr = 32'h8de2700b;
    int               cycle_cnt = 0;
    logic [TAG_W-1:0] model_tag [LINES]; // Tag model with FIFO replacement
    bit [LINES-1:0]   model_valid = '0;
    int               model_ptr = 0;

    always #2 mclk = ~mclk;  // 4 ns period

    icache_top #(.ADDR_W(ADDR_W), .LINES(LINES), .WORDS(WORDS)) DUT (
        .mclk          (mclk),
        .rst_n         (rst_n),
        .cpu_req_i     (cpu_req_i),
        .cpu_addr_i    (cpu_addr_i),
        .cpu_width_i   (cpu_width_i),
        .cpu_req_ack_o (cpu_req_ack_o),
        .cpu_rdata_o   (cpu_rdata_o),
        .cpu_resp_o    (cpu_resp_o),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_bl_o      (mem_bl_o),
        .mem_rdata_i   (mem_rdata_i),
        .mem_ack_i     (mem_ack_i),
        .mem_lack_i    (mem_lack_i)
    );

    //------------------------------------------------------------
    // Helpers
    //------------------------------------------------------------
    function automatic logic [31:0] mem_word(input logic [31:0] wa);
        return (wa * 32'h01010101) ^ 32'hc0de0000;  // Content rule of the memory
    endfunction

    // Expected CPU data for one read
    function automatic logic [31:0] ref_rdata(input logic [ADDR_W-1:0] addr,
                                              input logic [1:0] width);
        logic [31:0] w;
        logic [1:0]  ofs;
        w   = mem_word(32'(addr[ADDR_W-1:2]));
        ofs = addr[1:0];
        case (width)
            WIDTH_BYTE: return (w >> {ofs, 3'b000}) & 32'h000000ff;
            WIDTH_HALF: return (w >> {ofs[1], 4'b0000}) & 32'h0000ffff;  // Lower or upper half
            default:    return w;
        endcase
    endfunction

    // Round down to a line boundary
    function automatic logic [ADDR_W-1:0] line_base(input logic [ADDR_W-1:0] addr);
        return ADDR_W'((32'(addr) / LINE_BYTES) * LINE_BYTES);
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // Galois form
    endfunction

    // One LFSR step per bit taken
    task automatic draw(input int nbits, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic bit model_has(input logic [TAG_W-1:0] t);
        for (int i = 0; i < LINES; i++)
            if (model_valid[i] && model_tag[i] == t) return 1'b1;
        return 1'b0;
    endfunction

    task automatic model_insert(input logic [TAG_W-1:0] t);
        model_tag[model_ptr]   = t;
        model_valid[model_ptr] = 1'b1;
        model_ptr              = (model_ptr + 1) % LINES;  // Oldest line goes next
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got %h expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // One CPU read; mem_req_o activity is checked against the tag model
    task automatic do_read(input logic [ADDR_W-1:0] addr, input logic [1:0] width,
                           output bit missed);
        logic [TAG_W-1:0] tag;
        bit               predict_miss;
        bit               saw_req;
        int               lat;
        tag          = addr[ADDR_W-1:LINE_OFS];
        predict_miss = !model_has(tag);
        saw_req      = 1'b0;
        lat          = 0;
        exp_q.push_back(ref_rdata(addr, width));
        cpu_req_i   = 1'b1;
        cpu_addr_i  = addr;
        cpu_width_i = width;
        @(negedge mclk);
        while (!cpu_req_ack_o) @(negedge mclk);
        cpu_req_i = 1'b0;                       // Release the request once acked
        while (cpu_resp_o != RESP_LAST) begin
            @(negedge mclk);
            lat++;
            if (mem_req_o && !saw_req) begin
                saw_req = 1'b1;
                check("mem_addr_o", 32'(mem_addr_o), 32'(line_base(addr)));
                check("mem_bl_o", 32'(mem_bl_o), 32'(WORDS));   // Whole line burst
            end
        end
        check("mem_req_o raised", 32'(saw_req), 32'(predict_miss));
        if (!predict_miss) check("hit latency", 32'(lat), 32'd3);
        if (predict_miss) model_insert(tag);
        missed = saw_req;
    endtask

    //------------------------------------------------------------
    // Memory model with two idle cycles then WORDS acks
    //------------------------------------------------------------
    initial begin
        logic [31:0] base;
        mem_ack_i   = 1'b0;
        mem_lack_i  = 1'b0;
        mem_rdata_i = '0;
        forever begin
            @(negedge mclk);
            if (rst_n && mem_req_o) begin
                base = 32'(mem_addr_o[ADDR_W-1:2]);
                repeat (2) @(negedge mclk);
                for (int i = 0; i < WORDS; i++) begin
                    mem_ack_i   = 1'b1;
                    mem_rdata_i = mem_word(base + 32'(i));
                    mem_lack_i  = (i == WORDS - 1);  // Last word of the burst
                    @(negedge mclk);
                end
                mem_ack_i  = 1'b0;
                mem_lack_i = 1'b0;
            end
        end
    end

    // Compare each response with the queued expectation
    always @(negedge mclk) begin
        if (rst_n && cpu_resp_o == RESP_LAST) begin
            if (exp_q.size() == 0) begin
                $display("A response came back with no read outstanding");
                $display("Simulation failed");
                $fatal(1, "unexpected response");
            end else begin
                check("cpu_rdata_o", cpu_rdata_o, exp_q.pop_front());
            end
        end
    end

    always @(posedge mclk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Timeout after %0d cycles, the cache stopped answering", cycle_cnt);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    //------------------------------------------------------------
    // Stimulus
    //------------------------------------------------------------
    initial begin
        bit                missed;
        logic [31:0]       r_line;
        logic [31:0]       r_word;
        logic [31:0]       r_ofs;
        logic [31:0]       r_width;
        logic [1:0]        width;
        logic [ADDR_W-1:0] addr;
        rst_n       = 1'b0;
        cpu_req_i   = 1'b0;
        cpu_addr_i  = '0;
        cpu_width_i = WIDTH_WORD;
        repeat (16) @(negedge mclk);
        rst_n = 1'b1;

        repeat (4) begin                         // Quiet after reset
            @(negedge mclk);
            check("cpu_req_ack_o", 32'(cpu_req_ack_o), 32'd0);
            check("cpu_resp_o", 32'(cpu_resp_o), 32'(RESP_NONE));
            check("mem_req_o", 32'(mem_req_o), 32'd0);
        end

        do_read(16'h0124, WIDTH_WORD, missed);   // Cold miss
        check("mem_req_o on first read", 32'(missed), 32'd1);

        for (int w = 0; w < WORDS; w++) begin
            do_read(ADDR_W'(32'h0120 + w * 4), WIDTH_WORD, missed);
            check("mem_req_o on same line", 32'(missed), 32'd0);
        end

        for (int ofs = 0; ofs < 4; ofs++) begin  // Lane select at every offset
            do_read(ADDR_W'(32'h0128 + ofs), WIDTH_BYTE, missed);
            do_read(ADDR_W'(32'h012c + ofs), WIDTH_HALF, missed);
        end

        // LINES+1 fresh lines push the first one out
        for (int k = 0; k <= LINES; k++) begin
            do_read(ADDR_W'(32'h8000 + k * LINE_BYTES + 4), WIDTH_WORD, missed);
            check("mem_req_o on fresh line", 32'(missed), 32'd1);
        end
        do_read(16'h8003, WIDTH_BYTE, missed);
        check("mem_req_o on evicted line", 32'(missed), 32'd1);
        do_read(ADDR_W'(32'h8000 + LINES * LINE_BYTES + 14), WIDTH_HALF, missed);
        check("mem_req_o on second newest line", 32'(missed), 32'd0);

        for (int n = 0; n < N_RAND; n++) begin
            draw(IDX_W + 1, r_line);
            draw(WPTR_W, r_word);
            draw(2, r_ofs);
            draw(2, r_width);
            width = (r_width[1:0] == 2'b11) ? WIDTH_WORD : r_width[1:0];
            addr  = ADDR_W'(RAND_BASE + r_line * LINE_BYTES + r_word * 4 + r_ofs);
            do_read(addr, width, missed);
        end

        repeat (2) @(negedge mclk);              // A stray response shows up here
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
src/icache_pkg.sv
src/icache_fill_if.sv
src/icache_refill.sv
src/icache_line_store.sv
src/icache_lookup.sv
src/icache_top.sv
dv/icache_assertions.sv
dv/tb_icache.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_icache -f sim.f -o Vtb_icache

./obj_dir/Vtb_icache 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
grep -q "Simulation passed" sim.log
